// File: mmc_pkg.sv
/*
 * Shared definitions for the MMC/SD SPI-mode block device controller:
 * card command bytes, tokens, sector sizes, SPI clock dividers and the
 * structs passed between the sequencer, the datapath and the SPI engine.
 */
package mmc_pkg;

   localparam int sector_words = 256;
   localparam int block_bytes = 512;

   // command index bytes, start and transmission bits included
   localparam logic [7:0] cmd_go_idle = 8'h40;
   localparam logic [7:0] cmd_send_op_cond = 8'h41;
   localparam logic [7:0] cmd_set_blocklen = 8'h50;
   localparam logic [7:0] cmd_read_single = 8'h51;
   localparam logic [7:0] cmd_write_single = 8'h58;

   localparam logic [7:0] crc_cmd0 = 8'h95;
   // card ignores crc once in spi mode
   localparam logic [7:0] crc_none = 8'h01;

   localparam logic [7:0] token_start = 8'hfe;
   localparam logic [7:0] byte_idle = 8'hff;
   localparam logic [7:0] r1_idle = 8'h01;
   localparam logic [7:0] r1_ready = 8'h00;

   localparam int init_clocks = 80;
   // sclk half period, counted in pairs of clk cycles
   localparam int div_slow = 4;
   localparam int div_fast = 1;

   typedef enum logic [2:0] {
      spi_none,
      spi_init,
      spi_send,
      spi_write,
      spi_read,
      spi_stop
   } spi_op_t;

   typedef struct packed {
      spi_op_t     op;
      logic [47:0] frame;
      logic [7:0]  data;
      logic        fast;
   } spi_req_t;

   typedef struct packed {
      logic       done;
      logic [7:0] rx;
   } spi_rsp_t;

   typedef enum logic [1:0] {
      host_reset = 2'd0,
      host_read = 2'd1,
      host_write = 2'd2
   } host_cmd_t;

   // one-cycle strobes from the sequencer to the sector datapath
   typedef struct packed {
      logic load_addr;
      logic clr_word;
      logic inc_word;
      logic cap_write;
      logic cap_lo;
      logic cap_hi;
   } dp_ctrl_t;

endpackage

// File: mmc_spi_engine.sv
/*
 * SPI master for the card. Takes one request at a time from the sequencer
 * (init clocks, a 48-bit command frame, a byte out, a byte in or a stop
 * byte), runs it at slow or fast speed and returns done with the last byte.
 */
module mmc_spi_engine (
   input  logic              clk,
   input  logic              reset,
   input  mmc_pkg::spi_req_t req,
   output mmc_pkg::spi_rsp_t rsp,
   output logic              mmc_cs,
   output logic              mmc_sclk,
   output logic              mmc_do,
   input  logic              mmc_di
);

   logic        done;
   logic        speed;
   logic        tx_en;
   logic [3:0]  div_cnt;
   logic [3:0]  div_last;
   logic [7:0]  halves;
   logic [7:0]  half_count;
   logic [47:0] shift;
   logic        accept;
   logic        tick;

   assign accept = done && (req.op != mmc_pkg::spi_none);
   assign div_last = speed ? 4'(2 * mmc_pkg::div_fast - 1) : 4'(2 * mmc_pkg::div_slow - 1);
   assign tick = !done && (div_cnt == div_last);

   // sclk edges per operation
   always_comb
   begin
      case (req.op)
         mmc_pkg::spi_init: half_count = 8'(2 * mmc_pkg::init_clocks);
         mmc_pkg::spi_send: half_count = 8'd96;
         default:           half_count = 8'd16;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         done <= 1'b1;
         speed <= 1'b0;
         tx_en <= 1'b0;
         div_cnt <= '0;
         halves <= '0;
         mmc_cs <= 1'b1;
         mmc_sclk <= 1'b0;
         mmc_do <= 1'b1;
      end
      else if (accept)
      begin
         done <= 1'b0;
         speed <= req.fast;
         tx_en <= (req.op == mmc_pkg::spi_send) || (req.op == mmc_pkg::spi_write);
         div_cnt <= '0;
         halves <= half_count;
         if (req.op == mmc_pkg::spi_send)
            mmc_cs <= 1'b0;
         else if (req.op == mmc_pkg::spi_init || req.op == mmc_pkg::spi_stop)
            mmc_cs <= 1'b1;
         if (req.op == mmc_pkg::spi_send)
            mmc_do <= req.frame[47];
         else if (req.op == mmc_pkg::spi_write)
            mmc_do <= req.data[7];
         else
            mmc_do <= 1'b1;
      end
      else if (tick)
      begin
         div_cnt <= '0;
         mmc_sclk <= !mmc_sclk;
         halves <= halves - 8'd1;
         // next bit goes out on the falling edge, line idles high
         if (mmc_sclk)
            mmc_do <= (tx_en && halves != 8'd1) ? shift[47] : 1'b1;
         if (halves == 8'd1)
            done <= 1'b1;
      end
      else if (!done)
      begin
         div_cnt <= div_cnt + 4'd1;
      end
   end

   // input sampled on the rising edge
   always_ff @(posedge clk)
   begin
      if (accept)
         shift <= (req.op == mmc_pkg::spi_send) ? req.frame : {req.data, 40'd0};
      else if (tick && !mmc_sclk)
         shift <= {shift[46:0], mmc_di};
   end

   assign rsp = '{done: done, rx: shift[7:0]};

endmodule

// File: mmc_sector_datapath.sv
/*
 * Sector datapath. Holds the host write word and the assembled read word,
 * counts the words of one sector and forms the card byte address from
 * the host sector address when a command is started.
 */
module mmc_sector_datapath (
   input  logic              clk,
   input  logic              reset,
   input  logic              start,
   input  logic [22:0]       sector_addr,
   input  logic [15:0]       write_word,
   input  logic [7:0]        rx_byte,
   input  mmc_pkg::dp_ctrl_t ctrl,
   output logic [15:0]       read_word,
   output logic [7:0]        write_lo,
   output logic [7:0]        write_hi,
   output logic [31:0]       byte_addr,
   output logic              last_word
);

   localparam int cnt_bits = $clog2(mmc_pkg::sector_words);

   logic [cnt_bits-1:0] word_cnt;
   logic [15:0]         write_hold;

   always_ff @(posedge clk)
   begin
      if (reset)
         word_cnt <= '0;
      else if (ctrl.clr_word)
         word_cnt <= '0;
      else if (ctrl.inc_word)
         word_cnt <= word_cnt + 1'b1;
   end

   assign last_word = (word_cnt == cnt_bits'(mmc_pkg::sector_words - 1));

   // low byte arrives first on the card
   always_ff @(posedge clk)
   begin
      if (ctrl.cap_lo)
         read_word[7:0] <= rx_byte;
      if (ctrl.cap_hi)
         read_word[15:8] <= rx_byte;
      if (ctrl.cap_write)
         write_hold <= write_word;
      if (start && ctrl.load_addr)
         byte_addr <= 32'(sector_addr) * 32'(mmc_pkg::block_bytes);
   end

   assign write_lo = write_hold[7:0];
   assign write_hi = write_hold[15:8];

endmodule

// File: mmc_card_sequencer.sv
/*
 * Card protocol FSM. Runs the SPI-mode start-up sequence, single block
 * read and single block write, drives the SPI engine one request at a
 * time and paces the host through the bd_* handshake.
 */
module mmc_card_sequencer (
   input  logic               clk,
   input  logic               reset,
   input  logic               bd_start,
   input  mmc_pkg::host_cmd_t bd_cmd,
   input  logic               bd_rd,
   input  logic               bd_wr,
   output logic               bd_bsy,
   output logic               bd_rdy,
   output logic               bd_iordy,
   output logic               bd_err,
   output mmc_pkg::spi_req_t  spi_req,
   input  mmc_pkg::spi_rsp_t  spi_rsp,
   output mmc_pkg::dp_ctrl_t  dp_ctrl,
   input  logic               last_word,
   input  logic [7:0]         write_lo,
   input  logic [7:0]         write_hi,
   input  logic [31:0]        byte_addr
);

   typedef enum logic [4:0] {
      s_idle, s_stop,
      r_init, r_cmd0, r_resp0, r_cmd1, r_resp1, r_cmd16, r_resp16, r_fin,
      c_cmd, c_resp,
      d_token, d_lo, d_hi, d_host, d_crc0, d_crc1,
      w_token, w_wait, w_lo, w_hi, w_ack, w_crc0, w_crc1, w_resp, w_busy
   } state_t;

   state_t             state;
   state_t             after_stop;
   mmc_pkg::host_cmd_t cmd_hold;
   mmc_pkg::spi_op_t   op;
   logic [47:0]        frame;
   logic [7:0]         data;
   logic [7:0]         cmd_rw;
   logic [7:0]         rx;
   logic               pending;
   logic               inited;
   logic               err;
   logic               xfer;

   assign rx = spi_rsp.rx;
   assign xfer = pending && spi_rsp.done;
   assign cmd_rw = (cmd_hold == mmc_pkg::host_write) ? mmc_pkg::cmd_write_single
                                                     : mmc_pkg::cmd_read_single;

   always_comb
   begin
      case (state)
         r_init:  op = mmc_pkg::spi_init;
         r_cmd0, r_cmd1, r_cmd16, c_cmd: op = mmc_pkg::spi_send;
         w_token, w_lo, w_hi, w_crc0, w_crc1: op = mmc_pkg::spi_write;
         s_stop:  op = mmc_pkg::spi_stop;
         s_idle, r_fin, d_host, w_wait, w_ack: op = mmc_pkg::spi_none;
         default: op = mmc_pkg::spi_read;
      endcase
      case (state)
         r_cmd0:  frame = {mmc_pkg::cmd_go_idle, 32'd0, mmc_pkg::crc_cmd0};
         r_cmd1:  frame = {mmc_pkg::cmd_send_op_cond, 32'd0, mmc_pkg::crc_none};
         r_cmd16: frame = {mmc_pkg::cmd_set_blocklen, 32'(mmc_pkg::block_bytes),
                           mmc_pkg::crc_none};
         default: frame = {cmd_rw, byte_addr, mmc_pkg::crc_none};
      endcase
      case (state)
         w_token: data = mmc_pkg::token_start;
         w_lo:    data = write_lo;
         w_hi:    data = write_hi;
         default: data = mmc_pkg::byte_idle;
      endcase
   end

   // op is dropped once the engine has taken the request
   assign spi_req = '{op: pending ? mmc_pkg::spi_none : op, frame: frame, data: data,
                      fast: inited};

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= s_idle;
         after_stop <= s_idle;
         cmd_hold <= mmc_pkg::host_reset;
         pending <= 1'b0;
         inited <= 1'b0;
         err <= 1'b0;
      end
      else
      begin
         if (op != mmc_pkg::spi_none)
            pending <= !spi_rsp.done;
         case (state)
            s_idle:
            begin
               if (bd_start && bd_cmd != 2'd3)
               begin
                  cmd_hold <= bd_cmd;
                  err <= 1'b0;
                  if (bd_cmd == mmc_pkg::host_reset)
                     inited <= 1'b0;
                  // auto init when no reset has been run yet
                  if (bd_cmd == mmc_pkg::host_reset || !inited)
                     state <= r_init;
                  else
                     state <= c_cmd;
               end
            end
            s_stop:   if (xfer) state <= after_stop;
            r_init:   if (xfer) state <= r_cmd0;
            r_cmd0:   if (xfer) state <= r_resp0;
            r_resp0:
            begin
               if (xfer && rx == mmc_pkg::r1_idle)
               begin
                  after_stop <= r_cmd1;
                  state <= s_stop;
               end
               else if (xfer && rx != mmc_pkg::byte_idle)
                  state <= r_init;
            end
            r_cmd1:   if (xfer) state <= r_resp1;
            r_resp1:
            begin
               if (xfer && rx != mmc_pkg::byte_idle)
               begin
                  after_stop <= (rx == mmc_pkg::r1_ready) ? r_cmd16 : r_cmd1;
                  state <= s_stop;
               end
            end
            r_cmd16:  if (xfer) state <= r_resp16;
            r_resp16:
            begin
               if (xfer && rx != mmc_pkg::byte_idle)
               begin
                  after_stop <= (rx == mmc_pkg::r1_ready) ? r_fin : r_cmd16;
                  state <= s_stop;
               end
            end
            r_fin:
            begin
               inited <= 1'b1;
               state <= (cmd_hold == mmc_pkg::host_reset) ? s_idle : c_cmd;
            end
            c_cmd:    if (xfer) state <= c_resp;
            c_resp:
            begin
               if (xfer && rx == mmc_pkg::r1_ready)
                  state <= (cmd_hold == mmc_pkg::host_write) ? w_token : d_token;
               else if (xfer && rx != mmc_pkg::byte_idle)
               begin
                  err <= 1'b1;
                  after_stop <= s_idle;
                  state <= s_stop;
               end
            end
            d_token:  if (xfer && rx == mmc_pkg::token_start) state <= d_lo;
            d_lo:     if (xfer) state <= d_hi;
            d_hi:     if (xfer) state <= d_host;
            d_host:   if (bd_rd) state <= last_word ? d_crc0 : d_lo;
            d_crc0:   if (xfer) state <= d_crc1;
            w_token:  if (xfer) state <= w_wait;
            w_wait:   if (bd_wr) state <= w_lo;
            w_lo:     if (xfer) state <= w_hi;
            w_hi:     if (xfer) state <= w_ack;
            w_ack:    if (!bd_wr) state <= last_word ? w_crc0 : w_wait;
            w_crc0:   if (xfer) state <= w_crc1;
            w_crc1:   if (xfer) state <= w_resp;
            w_resp:
            begin
               // data response is xxx0_0101 when accepted
               if (xfer && rx != mmc_pkg::byte_idle)
               begin
                  if (rx[4:0] != 5'b00101)
                     err <= 1'b1;
                  state <= w_busy;
               end
            end
            // d_crc1 and w_busy end the transfer with a stop byte
            default:
            begin
               if (xfer && (state == d_crc1 || rx != 8'h00))
               begin
                  after_stop <= s_idle;
                  state <= s_stop;
               end
            end
         endcase
      end
   end

   assign bd_bsy = (state != s_idle);
   assign bd_rdy = (state == s_idle) || (state == d_host) || (state == w_wait);
   assign bd_iordy = (state == d_host) || (state == w_ack);
   assign bd_err = err;

   assign dp_ctrl = '{
      load_addr: (state == s_idle),
      clr_word:  (state == c_resp) && xfer && (rx == mmc_pkg::r1_ready),
      inc_word:  ((state == d_host) && bd_rd) || ((state == w_ack) && !bd_wr),
      cap_write: (state == w_wait) && bd_wr,
      cap_lo:    (state == d_lo) && xfer,
      cap_hi:    (state == d_hi) && xfer
   };

endmodule

// File: mmc_block_dev.sv
/*
 * MMC/SD block device controller in SPI mode, top level. The host starts
 * a reset, read or write of one 512-byte sector and moves the data as
 * 16-bit words over the bd_* pins; the card hangs on the mmc_* pins.
 */
module mmc_block_dev (
   input  logic               clk,
   input  logic               reset,
   input  mmc_pkg::host_cmd_t bd_cmd,
   input  logic               bd_start,
   output logic               bd_bsy,
   output logic               bd_rdy,
   output logic               bd_err,
   input  logic [22:0]        bd_addr,
   input  logic [15:0]        bd_data_in,
   output logic [15:0]        bd_data_out,
   input  logic               bd_rd,
   input  logic               bd_wr,
   output logic               bd_iordy,
   output logic               mmc_cs,
   output logic               mmc_sclk,
   output logic               mmc_do,
   input  logic               mmc_di
);

   mmc_pkg::spi_req_t spi_req;
   mmc_pkg::spi_rsp_t spi_rsp;
   mmc_pkg::dp_ctrl_t dp_ctrl;
   logic              last_word;
   logic [7:0]        write_lo;
   logic [7:0]        write_hi;
   logic [31:0]       byte_addr;

   mmc_card_sequencer sequencer_inst (
      .clk       (clk),
      .reset     (reset),
      .bd_start  (bd_start),
      .bd_cmd    (bd_cmd),
      .bd_rd     (bd_rd),
      .bd_wr     (bd_wr),
      .bd_bsy    (bd_bsy),
      .bd_rdy    (bd_rdy),
      .bd_iordy  (bd_iordy),
      .bd_err    (bd_err),
      .spi_req   (spi_req),
      .spi_rsp   (spi_rsp),
      .dp_ctrl   (dp_ctrl),
      .last_word (last_word),
      .write_lo  (write_lo),
      .write_hi  (write_hi),
      .byte_addr (byte_addr)
   );

   mmc_sector_datapath datapath_inst (
      .clk         (clk),
      .reset       (reset),
      .start       (bd_start),
      .sector_addr (bd_addr),
      .write_word  (bd_data_in),
      .rx_byte     (spi_rsp.rx),
      .ctrl        (dp_ctrl),
      .read_word   (bd_data_out),
      .write_lo    (write_lo),
      .write_hi    (write_hi),
      .byte_addr   (byte_addr),
      .last_word   (last_word)
   );

   mmc_spi_engine spi_engine_inst (
      .clk      (clk),
      .reset    (reset),
      .req      (spi_req),
      .rsp      (spi_rsp),
      .mmc_cs   (mmc_cs),
      .mmc_sclk (mmc_sclk),
      .mmc_do   (mmc_do),
      .mmc_di   (mmc_di)
   );

endmodule

// File: mmc_card_model.sv
/*
 * Behavioural SPI-mode card for the testbench. Decodes command frames,
 * answers with R1, data blocks and data responses, holds one sector
 * and logs every command index and argument it receives.
 */
module mmc_card_model (
   input  logic mmc_cs,
   input  logic mmc_sclk,
   input  logic mmc_do,
   output logic mmc_di
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [7:0]  store [512];
   logic [7:0]  cmd_idx [$];
   logic [31:0] cmd_arg [$];
   logic        read_err;

   logic [7:0]  tx_q [$];
   logic [7:0]  frame [6];
   logic [7:0]  rx_sr;
   logic [7:0]  out_sr;
   int          bit_cnt;
   int          frame_n;
   int          data_n;
   int          op_polls;
   // 0 command, 1 waiting for start token, 2 write data
   int          mode;

   initial
   begin
      read_err = 1'b0;
      mmc_di = 1'b1;
      out_sr = 8'hff;
      bit_cnt = 0;
      frame_n = 0;
      mode = 0;
      op_polls = 0;
      for (int i = 0; i < 512; i++)
         store[i] = 8'(i) ^ {i[8], 7'h15};
   end

   task automatic do_command();
      logic [31:0] arg;
      arg = {frame[1], frame[2], frame[3], frame[4]};
      cmd_idx.push_back(frame[0]);
      cmd_arg.push_back(arg);
      case (frame[0])
         8'h40:
         begin
            op_polls = 0;
            tx_q.push_back(8'h01);
         end
         // still idle on the first poll
         8'h41:
         begin
            tx_q.push_back(op_polls < 1 ? 8'h01 : 8'h00);
            op_polls++;
         end
         8'h50: tx_q.push_back(8'h00);
         8'h51:
         begin
            if (read_err)
               tx_q.push_back(8'h04);
            else
            begin
               tx_q.push_back(8'h00);
               tx_q.push_back(8'hff);
               tx_q.push_back(8'hfe);
               for (int i = 0; i < 512; i++)
                  tx_q.push_back(store[i]);
               tx_q.push_back(8'haa);
               tx_q.push_back(8'h55);
            end
         end
         8'h58:
         begin
            tx_q.push_back(8'h00);
            mode = 1;
         end
         default: tx_q.push_back(8'h04);
      endcase
   endtask

   task automatic take_byte(input logic [7:0] b);
      case (mode)
         0:
         begin
            if (frame_n != 0 || b[7:6] == 2'b01)
            begin
               frame[frame_n] = b;
               frame_n++;
               if (frame_n == 6)
               begin
                  frame_n = 0;
                  do_command();
               end
            end
         end
         1:
         begin
            if (b == 8'hfe)
            begin
               mode = 2;
               data_n = 0;
            end
         end
         default:
         begin
            if (data_n < 512)
               store[data_n] = b;
            data_n++;
            // data accepted, then two busy bytes
            if (data_n == 514)
            begin
               tx_q.push_back(8'h05);
               tx_q.push_back(8'h00);
               tx_q.push_back(8'h00);
               mode = 0;
            end
         end
      endcase
   endtask

   always @(posedge mmc_sclk)
   begin
      if (!mmc_cs)
      begin
         rx_sr = {rx_sr[6:0], mmc_do};
         bit_cnt++;
         if (bit_cnt == 8)
         begin
            bit_cnt = 0;
            take_byte(rx_sr);
         end
      end
   end

   always @(negedge mmc_sclk)
   begin
      if (!mmc_cs)
      begin
         if (bit_cnt == 0)
            out_sr = (tx_q.size() > 0) ? tx_q.pop_front() : 8'hff;
         mmc_di = out_sr[7];
         out_sr = {out_sr[6:0], 1'b1};
      end
   end

   always @(posedge mmc_cs)
   begin
      mmc_di = 1'b1;
      out_sr = 8'hff;
      bit_cnt = 0;
      frame_n = 0;
      tx_q.delete();
   end

endmodule

// File: mmc_block_dev_asserts.sv
/*
 * Concurrent checks on the card SPI pins and the host port, bound into
 * the controller top level.
 */
module mmc_block_dev_asserts (
   input logic clk,
   input logic reset,
   input logic mmc_cs,
   input logic mmc_sclk,
   input logic mmc_do,
   input logic bd_bsy,
   input logic bd_iordy
);
   timeunit 1ns;
   timeprecision 100ps;

   // with the card deselected only init and stop clocks run, data line high
   sclk_with_cs_high: assert property (@(posedge clk) disable iff (reset)
      (mmc_cs && mmc_sclk != $past(mmc_sclk)) |-> mmc_do)
      else $error("sclk toggled with chip select high while data was driven");

   // host word handshake only mid-command, spi clock parked meanwhile
   iordy_needs_busy: assert property (@(posedge clk) disable iff (reset)
      bd_iordy |-> (bd_bsy && $stable(mmc_sclk)))
      else $error("bd_iordy high while idle or with sclk running");

   idle_deselects_card: assert property (@(posedge clk) disable iff (reset)
      !bd_bsy |-> mmc_cs)
      else $error("card selected while controller idle");

endmodule

bind mmc_block_dev mmc_block_dev_asserts asserts_inst (
   .clk      (clk),
   .reset    (reset),
   .mmc_cs   (mmc_cs),
   .mmc_sclk (mmc_sclk),
   .mmc_do   (mmc_do),
   .bd_bsy   (bd_bsy),
   .bd_iordy (bd_iordy)
);

// File: mmc_block_dev_tb.sv
/*
 * Testbench for the block device controller. Runs reset, write, read,
 * read error and auto-init sequences against the card model with
 * LFSR data, and checks words, card contents and command order.
 */
module mmc_block_dev_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int slow_byte_clk = 128;
   localparam int fast_byte_clk = 32;
   // init clocks plus four command rounds of about eight bytes
   localparam int init_bytes = 42;
   localparam int sector_bytes = 534;
   localparam int timeout_cycles = 8 * (slow_byte_clk * init_bytes +
      4 * (fast_byte_clk * sector_bytes + 4 * mmc_pkg::sector_words));

   logic               clk;
   logic               reset;
   mmc_pkg::host_cmd_t bd_cmd;
   logic               bd_start;
   logic               bd_bsy;
   logic               bd_rdy;
   logic               bd_err;
   logic [22:0]        bd_addr;
   logic [15:0]        bd_data_in;
   logic [15:0]        bd_data_out;
   logic               bd_rd;
   logic               bd_wr;
   logic               bd_iordy;
   logic               mmc_cs;
   logic               mmc_sclk;
   logic               mmc_do;
   logic               mmc_di;

   logic [15:0] ref_words [mmc_pkg::sector_words];
   logic [22:0] sector;
   logic [31:0] lfsr;
   logic [31:0] rnd;
   int          errors;
   int          cycles;
   int          pos;
   logic        saw_iordy;

   mmc_block_dev mmc_block_dev_inst (.*);

   mmc_card_model card_inst (
      .mmc_cs   (mmc_cs),
      .mmc_sclk (mmc_sclk),
      .mmc_do   (mmc_do),
      .mmc_di   (mmc_di)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= timeout_cycles)
      begin
         $display("run stopped by timeout after %0d cycles", cycles);
         $display("Test FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0])
         n = n ^ 32'h8020_0003;
      return n;
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v = {v[30:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("FAIL %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic hold_reset();
      reset <= 1'b1;
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);
      @(posedge clk);
   endtask

   task automatic start_cmd(input mmc_pkg::host_cmd_t cmd, input logic [22:0] addr);
      @(posedge clk);
      bd_cmd <= cmd;
      bd_addr <= addr;
      bd_start <= 1'b1;
      @(posedge clk);
      bd_start <= 1'b0;
      @(posedge clk);
      if (!bd_bsy)
      begin
         $display("bd_bsy did not rise after a start");
         errors++;
      end
   endtask

   task automatic wait_idle();
      while (bd_bsy)
         @(posedge clk);
   endtask

   // CMD0, one or more CMD1, then CMD16 with a 512 byte block
   task automatic check_init_log(output int next);
      int k;
      next = 0;
      if (card_inst.cmd_idx.size() < 3)
      begin
         $display("card saw too few commands during init");
         errors++;
         return;
      end
      check_value("cmd0_index", 32'(card_inst.cmd_idx[0]), 32'h40);
      k = 1;
      while (k < card_inst.cmd_idx.size() - 1 && card_inst.cmd_idx[k] == 8'h41)
         k++;
      if (k == 1)
      begin
         $display("card saw no CMD1 after CMD0");
         errors++;
      end
      check_value("cmd16_index", 32'(card_inst.cmd_idx[k]), 32'h50);
      check_value("cmd16_arg", card_inst.cmd_arg[k], 32'd512);
      next = k + 1;
   endtask

   task automatic read_sector();
      for (int i = 0; i < mmc_pkg::sector_words; i++)
      begin
         @(posedge clk);
         while (bd_bsy && !bd_iordy)
            @(posedge clk);
         if (!bd_bsy)
         begin
            $display("read ended early at word %0d", i);
            errors++;
            return;
         end
         // controller waits for the host here
         check_value("bd_rdy", 32'(bd_rdy), 32'd1);
         check_value($sformatf("bd_data_out[%0d]", i), 32'(bd_data_out), 32'(ref_words[i]));
         bd_rd <= 1'b1;
         @(posedge clk);
         bd_rd <= 1'b0;
      end
   endtask

   task automatic write_sector();
      for (int i = 0; i < mmc_pkg::sector_words; i++)
      begin
         @(posedge clk);
         while (bd_bsy && !bd_rdy)
            @(posedge clk);
         if (!bd_bsy)
         begin
            $display("write ended early at word %0d", i);
            errors++;
            return;
         end
         bd_data_in <= ref_words[i];
         bd_wr <= 1'b1;
         @(posedge clk);
         while (bd_bsy && !bd_iordy)
            @(posedge clk);
         bd_wr <= 1'b0;
      end
   endtask

   initial
   begin
      reset = 1'b1;
      bd_cmd = mmc_pkg::host_reset;
      bd_start = 1'b0;
      bd_addr = '0;
      bd_data_in = '0;
      bd_rd = 1'b0;
      bd_wr = 1'b0;
      errors = 0;
      cycles = 0;
      lfsr = 32'h875e_9d39;
      hold_reset();

      // idle after reset
      check_value("bd_bsy", 32'(bd_bsy), 32'd0);
      check_value("bd_rdy", 32'(bd_rdy), 32'd1);
      check_value("bd_iordy", 32'(bd_iordy), 32'd0);
      check_value("bd_err", 32'(bd_err), 32'd0);
      check_value("mmc_cs", 32'(mmc_cs), 32'd1);
      check_value("mmc_sclk", 32'(mmc_sclk), 32'd0);
      check_value("mmc_do", 32'(mmc_do), 32'd1);

      card_inst.cmd_idx.delete();
      card_inst.cmd_arg.delete();
      start_cmd(mmc_pkg::host_reset, '0);
      wait_idle();
      check_init_log(pos);

      // write one random sector
      take_bits(23, rnd);
      sector = rnd[22:0];
      for (int i = 0; i < mmc_pkg::sector_words; i++)
      begin
         take_bits(16, rnd);
         ref_words[i] = rnd[15:0];
      end
      card_inst.cmd_idx.delete();
      card_inst.cmd_arg.delete();
      start_cmd(mmc_pkg::host_write, sector);
      write_sector();
      wait_idle();
      check_value("bd_err", 32'(bd_err), 32'd0);
      if (card_inst.cmd_idx.size() < 1)
      begin
         $display("card saw no write command");
         errors++;
      end
      else
      begin
         check_value("cmd24_index", 32'(card_inst.cmd_idx[0]), 32'h58);
         check_value("cmd24_arg", card_inst.cmd_arg[0], 32'(sector) * 32'd512);
      end
      for (int i = 0; i < mmc_pkg::sector_words; i++)
      begin
         check_value($sformatf("card_lo[%0d]", i), 32'(card_inst.store[2 * i]),
                     32'(ref_words[i][7:0]));
         check_value($sformatf("card_hi[%0d]", i), 32'(card_inst.store[2 * i + 1]),
                     32'(ref_words[i][15:8]));
      end

      // read it back
      start_cmd(mmc_pkg::host_read, sector);
      read_sector();
      wait_idle();
      check_value("bd_err", 32'(bd_err), 32'd0);

      // rejected read
      card_inst.read_err = 1'b1;
      saw_iordy = 1'b0;
      start_cmd(mmc_pkg::host_read, sector);
      while (bd_bsy)
      begin
         if (bd_iordy)
            saw_iordy = 1'b1;
         @(posedge clk);
      end
      card_inst.read_err = 1'b0;
      check_value("bd_err", 32'(bd_err), 32'd1);
      if (saw_iordy)
      begin
         $display("bd_iordy rose during a rejected read");
         errors++;
      end
      start_cmd(mmc_pkg::host_reset, '0);
      check_value("bd_err", 32'(bd_err), 32'd0);
      wait_idle();

      // first read after a fresh reset runs init by itself
      hold_reset();
      card_inst.cmd_idx.delete();
      card_inst.cmd_arg.delete();
      start_cmd(mmc_pkg::host_read, sector);
      read_sector();
      wait_idle();
      check_init_log(pos);
      if (pos == 0 || card_inst.cmd_idx.size() <= pos)
      begin
         $display("card saw no read command after init");
         errors++;
      end
      else
      begin
         check_value("cmd17_index", 32'(card_inst.cmd_idx[pos]), 32'h51);
         check_value("cmd17_arg", card_inst.cmd_arg[pos], 32'(sector) * 32'd512);
      end

      $display("errors: %0d", errors);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

// File: mmc_block_dev.f
mmc_pkg.sv
mmc_spi_engine.sv
mmc_sector_datapath.sv
mmc_card_sequencer.sv
mmc_block_dev.sv
mmc_card_model.sv
mmc_block_dev_asserts.sv
mmc_block_dev_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the controller testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module mmc_block_dev_tb -f mmc_block_dev.f -o sim_tb
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
   exit 0
fi
exit 1
